// File: design/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	// major opcodes handled by this core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// register-register layout
	typedef struct packed {
		logic [6:0]              funct7;
		logic [`CORE_REG_AW-1:0] rs2;
		logic [`CORE_REG_AW-1:0] rs1;
		logic [2:0]              funct3;
		logic [`CORE_REG_AW-1:0] rd;
		opcode_e                 opcode;
	} r_fmt_t;

	// immediate layout, imm12 overlays funct7 and rs2
	typedef struct packed {
		logic [11:0]             imm12;
		logic [`CORE_REG_AW-1:0] rs1;
		logic [2:0]              funct3;
		logic [`CORE_REG_AW-1:0] rd;
		opcode_e                 opcode;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	// one decoded op as it travels to execute
	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    use_imm;
		logic                    illegal;
		logic [`CORE_REG_AW-1:0] rd;
		logic [`CORE_REG_AW-1:0] rs1;
		logic [`CORE_REG_AW-1:0] rs2;
		logic [`CORE_XLEN-1:0]   imm;
	} dec_op_t;

endpackage

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	op_wb_if.slave                  op_i,
	input  logic                    retire_ready_i,
	output logic                    retire_valid_o,
	output logic [`CORE_REG_AW-1:0] retire_rd_o,
	output logic [`CORE_XLEN-1:0]   retire_data_o,
	output logic                    retire_illegal_o
);
	import core_pkg::*;

	localparam int SHAMT_W = $clog2(`CORE_XLEN);

	logic                  accept;
	logic                  wr_en;
	logic [`CORE_XLEN-1:0] rs1_data;
	logic [`CORE_XLEN-1:0] rs2_data;
	logic [`CORE_XLEN-1:0] src_b;
	logic [`CORE_XLEN-1:0] result;
	logic [SHAMT_W-1:0]    shamt;

	// take a new op when the retire slot is empty or draining now
	assign op_i.ack = !retire_valid_o || retire_ready_i;
	assign accept = op_i.cyc && op_i.stb && op_i.ack;
	assign wr_en = accept && !op_i.dat.illegal;

	reg_file reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1_addr_i (op_i.dat.rs1),
		.rs2_addr_i (op_i.dat.rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (wr_en),
		.rd_addr_i  (op_i.dat.rd),
		.rd_data_i  (result)
	);

	assign src_b = op_i.dat.use_imm ? op_i.dat.imm : rs2_data;
	assign shamt = src_b[SHAMT_W-1:0];

	always_comb begin
		case (op_i.dat.alu_op)
			ALU_ADD:  result = rs1_data + src_b;
			ALU_SUB:  result = rs1_data - src_b;
			ALU_AND:  result = rs1_data & src_b;
			ALU_OR:   result = rs1_data | src_b;
			ALU_XOR:  result = rs1_data ^ src_b;
			ALU_SLT:  result = `CORE_XLEN'($signed(rs1_data) < $signed(src_b));
			ALU_SLTU: result = `CORE_XLEN'(rs1_data < src_b);
			ALU_SLL:  result = rs1_data << shamt;
			ALU_SRL:  result = rs1_data >> shamt;
			ALU_SRA:  result = $unsigned($signed(rs1_data) >>> shamt);
			default:  result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid_o <= 1'b0;
		end else if (accept) begin
			retire_valid_o <= 1'b1;
		end else if (retire_ready_i) begin
			retire_valid_o <= 1'b0;
		end
	end

	// report what rd holds after the write
	always_ff @(posedge clk) begin
		if (accept) begin
			retire_rd_o <= op_i.dat.rd;
			retire_illegal_o <= op_i.dat.illegal;
			if (op_i.dat.illegal || op_i.dat.rd == '0) begin
				retire_data_o <= '0;
			end else begin
				retire_data_o <= result;
			end
		end
	end

	retire_held: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o && !retire_ready_i |=>
			retire_valid_o && $stable(retire_rd_o) && $stable(retire_data_o) &&
			$stable(retire_illegal_o));

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module inst_decoder (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             ins_cyc_i,
	input  logic             ins_stb_i,
	input  core_pkg::instr_u ins_dat_i,
	output logic             ins_ack_o,
	op_wb_if.master          op_o
);
	import core_pkg::*;

	dec_op_t dec;
	dec_op_t slot_q;
	logic    slot_vld;
	logic    slot_free;
	logic    capture;
	logic    f7_zero;
	logic    f7_alt;

	// default op for each funct3, alternate forms patched below
	function automatic alu_op_e base_op(input logic [2:0] funct3);
		case (funct3)
			3'b000:  return ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign f7_zero = ins_dat_i.r.funct7 == 7'b0000000;
	assign f7_alt = ins_dat_i.r.funct7 == 7'b0100000;

	always_comb begin
		dec.alu_op = base_op(ins_dat_i.r.funct3);
		dec.use_imm = 1'b0;
		dec.illegal = 1'b0;
		dec.rd = ins_dat_i.r.rd;
		dec.rs1 = ins_dat_i.r.rs1;
		dec.rs2 = ins_dat_i.r.rs2;
		dec.imm = {{(`CORE_XLEN - 12){ins_dat_i.i.imm12[11]}}, ins_dat_i.i.imm12};
		case (ins_dat_i.r.opcode)
			OPC_OP: begin
				if (f7_alt && ins_dat_i.r.funct3 == 3'b000) begin
					dec.alu_op = ALU_SUB;
				end else if (f7_alt && ins_dat_i.r.funct3 == 3'b101) begin
					dec.alu_op = ALU_SRA;
				end else if (!f7_zero) begin
					dec.illegal = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				dec.use_imm = 1'b1;
				// shifts keep funct7 in the upper immediate bits
				if (ins_dat_i.r.funct3[1:0] == 2'b01) begin
					if (f7_alt && ins_dat_i.r.funct3[2]) begin
						dec.alu_op = ALU_SRA;
					end else if (!f7_zero) begin
						dec.illegal = 1'b1;
					end
				end
			end
			default: dec.illegal = 1'b1;
		endcase
	end

	// slot may refill on the edge it drains
	assign slot_free = !slot_vld || op_o.ack;
	assign capture = ins_cyc_i && ins_stb_i && !ins_ack_o && slot_free;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ins_ack_o <= 1'b0;
			slot_vld <= 1'b0;
		end else begin
			ins_ack_o <= capture;
			if (capture) begin
				slot_vld <= 1'b1;
			end else if (op_o.ack) begin
				slot_vld <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			slot_q <= dec;
		end
	end

	assign op_o.cyc = slot_vld;
	assign op_o.stb = slot_vld;
	assign op_o.dat = slot_q;

	// the master keeps the word on the bus until it is acked
	word_held: assert property (@(posedge clk) disable iff (!rst_n)
		ins_cyc_i && ins_stb_i && !ins_ack_o |=> ins_stb_i && $stable(ins_dat_i));

endmodule

`default_nettype wire

// File: design/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module issue_queue (
	input  logic    clk,
	input  logic    rst_n,
	op_wb_if.slave  wr_i,
	op_wb_if.master rd_o
);
	import core_pkg::*;

	localparam int DEPTH = `CORE_IQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dec_op_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap explicitly so any depth works
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign wr_i.ack = count != CNT_W'(DEPTH);
	assign push = wr_i.cyc && wr_i.stb && wr_i.ack;

	assign rd_o.cyc = count != '0;
	assign rd_o.stb = count != '0;
	assign rd_o.dat = mem[rd_ptr];
	assign pop = rd_o.stb && rd_o.ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_i.dat;
		end
	end

	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: design/op_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic link carrying decoded ops
interface op_wb_if;
	import core_pkg::*;

	logic    cyc;
	logic    stb;
	logic    ack;
	dec_op_t dat;

	modport master (
		output cyc,
		output stb,
		output dat,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  dat,
		output ack
	);

endinterface

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`CORE_REG_AW-1:0] rs1_addr_i,
	input  logic [`CORE_REG_AW-1:0] rs2_addr_i,
	output logic [`CORE_XLEN-1:0]   rs1_data_o,
	output logic [`CORE_XLEN-1:0]   rs2_data_o,
	input  logic                    we_i,
	input  logic [`CORE_REG_AW-1:0] rd_addr_i,
	input  logic [`CORE_XLEN-1:0]   rd_data_i
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_addr_i != '0) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// x0 is hard-wired
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_alu_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ins_cyc_i,
	input  logic                    ins_stb_i,
	// write-only port, we is not decoded
	input  logic                    ins_we_i,
	input  logic [`CORE_XLEN-1:0]   ins_dat_i,
	output logic                    ins_ack_o,
	input  logic                    retire_ready_i,
	output logic                    retire_valid_o,
	output logic [`CORE_REG_AW-1:0] retire_rd_o,
	output logic [`CORE_XLEN-1:0]   retire_data_o,
	output logic                    retire_illegal_o
);

	op_wb_if dec_to_iq ();
	op_wb_if iq_to_ex ();

	inst_decoder inst_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.ins_cyc_i (ins_cyc_i),
		.ins_stb_i (ins_stb_i),
		.ins_dat_i (ins_dat_i),
		.ins_ack_o (ins_ack_o),
		.op_o      (dec_to_iq.master)
	);

	issue_queue issue_queue (
		.clk   (clk),
		.rst_n (rst_n),
		.wr_i  (dec_to_iq.slave),
		.rd_o  (iq_to_ex.master)
	);

	exec_unit exec_unit (
		.clk              (clk),
		.rst_n            (rst_n),
		.op_i             (iq_to_ex.slave),
		.retire_ready_i   (retire_ready_i),
		.retire_valid_o   (retire_valid_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

endmodule

`default_nettype wire

// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and instruction word width
`define CORE_XLEN 32

// architectural register file
`define CORE_NUM_REGS 32
`define CORE_REG_AW 5

// decoded ops buffered between decode and execute
`define CORE_IQ_DEPTH 4

`endif

// File: src.f
+incdir+include
design/core_pkg.sv
design/op_wb_if.sv
design/inst_decoder.sv
design/issue_queue.sv
design/reg_file.sv
design/exec_unit.sv
design/rv_alu_core.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [127:0] test_name_i,
	input  logic         ins_stb_i,
	input  logic         ins_ack_i,
	input  logic [31:0]  ins_dat_i,
	input  logic         retire_valid_i,
	input  logic         retire_ready_i,
	input  logic [4:0]   retire_rd_i,
	input  logic [31:0]  retire_data_i,
	input  logic         retire_illegal_i,
	output int           err_count_o,
	output int           pending_o
);

	logic [31:0] model_regs [32];
	// {illegal, rd, data} of each accepted word, oldest first
	logic [37:0] expected_q [$];
	logic [37:0] actual;
	logic [37:0] exp_rec;
	logic [37:0] held_rec;
	logic        held;

	assign actual = {retire_illegal_i, retire_rd_i, retire_data_i};

	// reference decode and ALU, updates the register model
	function automatic logic [37:0] apply_word(input logic [31:0] w);
		logic [6:0]         funct7;
		logic [2:0]         funct3;
		logic [4:0]         rd;
		logic [31:0]        b;
		logic [31:0]        res;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic               alt;
		logic               bad;
		funct7 = w[31:25];
		funct3 = w[14:12];
		rd = w[11:7];
		sa = model_regs[w[19:15]];
		alt = funct7 == 7'b0100000;
		bad = 1'b0;
		if (w[6:0] == 7'b0110011) begin
			b = model_regs[w[24:20]];
			bad = funct7 != 7'd0 && !(alt && (funct3 == 3'b000 || funct3 == 3'b101));
		end else if (w[6:0] == 7'b0010011) begin
			b = {{20{w[31]}}, w[31:20]};
			// only SRAI has an alternate form
			alt = alt && funct3 == 3'b101;
			if (funct3 == 3'b001 || funct3 == 3'b101) begin
				bad = funct7 != 7'd0 && !alt;
			end
		end else begin
			b = '0;
			bad = 1'b1;
		end
		sb = b;
		case (funct3)
			3'b000: res = alt ? sa - b : sa + b;
			3'b001: res = sa << b[4:0];
			3'b010: res = {31'b0, sa < sb};
			3'b011: res = {31'b0, $unsigned(sa) < b};
			3'b100: res = sa ^ b;
			3'b101: begin
				if (alt) begin
					res = sa >>> b[4:0];
				end else begin
					res = $unsigned(sa) >> b[4:0];
				end
			end
			3'b110: res = sa | b;
			default: res = sa & b;
		endcase
		if (bad || rd == 5'd0) begin
			res = '0;
		end else begin
			model_regs[rd] = res;
		end
		return {bad, rd, res};
	endfunction

	initial begin
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		err_count_o = 0;
		pending_o = 0;
		held = 1'b0;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (ins_stb_i && ins_ack_i) begin
				expected_q.push_back(apply_word(ins_dat_i));
			end
			if (held && (!retire_valid_i || actual !== held_rec)) begin
				$display("test %0s: retire outputs changed while retire_ready_i was low",
					test_name_i);
				err_count_o++;
			end
			held = retire_valid_i && !retire_ready_i;
			held_rec = actual;
			if (retire_valid_i && retire_ready_i) begin
				if (expected_q.size() == 0) begin
					$display("test %0s: x%0d retired but no instruction was outstanding",
						test_name_i, retire_rd_i);
					err_count_o++;
				end else begin
					exp_rec = expected_q.pop_front();
					if (exp_rec !== actual) begin
						$write("[ERROR] %0s: expected rd=x%0d data=%h illegal=%b",
							test_name_i, exp_rec[36:32], exp_rec[31:0], exp_rec[37]);
						$display(", actual rd=x%0d data=%h illegal=%b",
							retire_rd_i, retire_data_i, retire_illegal_i);
						err_count_o++;
					end
				end
			end
			pending_o = expected_q.size();
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam logic [31:0] SEED = 32'd75905;
	localparam logic [6:0] OPC_R = 7'b0110011;
	localparam logic [6:0] OPC_I = 7'b0010011;
	localparam int N_RESET = 8;
	localparam int N_RTYPE = 60;
	localparam int N_ITYPE = 60;
	localparam int N_CHAIN = 40;
	localparam int N_STALL = 60;
	localparam int N_ILLEGAL = 40;
	localparam int TOTAL_INSTR = N_RESET + N_RTYPE + N_ITYPE + N_CHAIN + N_STALL + N_ILLEGAL;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20 + RESET_CYCLES;

	// instruction mixes
	localparam int KIND_R = 0;
	localparam int KIND_I = 1;
	localparam int KIND_CHAIN = 2;
	localparam int KIND_MIX = 3;
	localparam int KIND_ILLEGAL = 4;

	logic         clk;
	logic         rst_n;
	logic         ins_cyc;
	logic         ins_stb;
	logic         ins_we;
	logic [31:0]  ins_dat;
	logic         ins_ack;
	logic         retire_ready;
	logic         retire_valid;
	logic [4:0]   retire_rd;
	logic [31:0]  retire_data;
	logic         retire_illegal;
	logic [127:0] test_name;
	logic [31:0]  lfsr;
	logic [31:0]  rdy_lfsr;
	logic [2:0]   rdy_bits;
	logic [4:0]   prev_rd;
	logic         stall_mode;
	int           chk_errors;
	int           pending;
	int           tb_errors;
	int           err_mark;
	int           tests_run;
	int           tests_failed;

	rv_alu_core dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.ins_cyc_i        (ins_cyc),
		.ins_stb_i        (ins_stb),
		.ins_we_i         (ins_we),
		.ins_dat_i        (ins_dat),
		.ins_ack_o        (ins_ack),
		.retire_ready_i   (retire_ready),
		.retire_valid_o   (retire_valid),
		.retire_rd_o      (retire_rd),
		.retire_data_o    (retire_data),
		.retire_illegal_o (retire_illegal)
	);

	tb_checker chk (
		.clk              (clk),
		.rst_n            (rst_n),
		.test_name_i      (test_name),
		.ins_stb_i        (ins_stb),
		.ins_ack_i        (ins_ack),
		.ins_dat_i        (ins_dat),
		.retire_valid_i   (retire_valid),
		.retire_ready_i   (retire_ready),
		.retire_rd_i      (retire_rd),
		.retire_data_i    (retire_data),
		.retire_illegal_i (retire_illegal),
		.err_count_o      (chk_errors),
		.pending_o        (pending)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] gen_word(input int kind);
		logic [6:0]  funct7;
		logic [6:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  funct3;
		logic [11:0] imm;
		logic [1:0]  sel;
		logic        use_r;
		logic        alt;
		funct3 = 3'(rand_bits(3));
		rd = 5'(rand_bits(5));
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		imm = 12'(rand_bits(12));
		alt = rand_bits(1) != 0;
		use_r = kind == KIND_R || (kind != KIND_I && rand_bits(1) != 0);
		if (kind == KIND_ILLEGAL) begin
			sel = 2'(rand_bits(2));
			// bit 0 set rules out both legal funct7 values
			funct7 = 7'(rand_bits(7)) | 7'b0000001;
			if (sel == 2'd2) begin
				return {funct7, rs2, rs1, funct3, rd, OPC_R};
			end else if (sel == 2'd3) begin
				funct3 = alt ? 3'b101 : 3'b001;
				return {funct7, rs2, rs1, funct3, rd, OPC_I};
			end
			opcode = 7'(rand_bits(7));
			if (opcode == OPC_R || opcode == OPC_I) begin
				opcode = opcode ^ 7'b0000100;
			end
			return {imm, rs1, funct3, rd, opcode};
		end
		if (kind == KIND_CHAIN) begin
			rs1 = prev_rd;
			rs2 = prev_rd;
			if (rand_bits(2) == 0) begin
				rd = 5'd0;
			end
			prev_rd = rd;
		end
		if (use_r) begin
			funct7 = (alt && (funct3 == 3'b000 || funct3 == 3'b101)) ? 7'b0100000 : 7'd0;
			return {funct7, rs2, rs1, funct3, rd, OPC_R};
		end
		if (funct3 == 3'b001 || funct3 == 3'b101) begin
			imm[11:5] = (alt && funct3 == 3'b101) ? 7'b0100000 : 7'd0;
		end
		return {imm, rs1, funct3, rd, OPC_I};
	endfunction

	// returns on the falling edge before the completing rising edge
	task automatic send_word(input logic [31:0] word);
		@(negedge clk);
		ins_cyc = 1'b1;
		ins_stb = 1'b1;
		ins_dat = word;
		do begin
			@(negedge clk);
		end while (!ins_ack);
	endtask

	task automatic run_traffic(input int kind, input int count, input logic stall);
		int i;
		logic [31:0] word;
		stall_mode = stall;
		for (i = 0; i < count; i++) begin
			if (kind == KIND_ILLEGAL && i[0]) begin
				word = gen_word(KIND_MIX);
			end else begin
				word = gen_word(kind);
			end
			send_word(word);
		end
		@(negedge clk);
		ins_cyc = 1'b0;
		ins_stb = 1'b0;
		while (pending != 0) begin
			@(negedge clk);
		end
		stall_mode = 1'b0;
	endtask

	task automatic start_test(input logic [127:0] name);
		test_name = name;
		err_mark = chk_errors + tb_errors;
	endtask

	task automatic end_test(input int count);
		tests_run++;
		if (chk_errors + tb_errors == err_mark) begin
			$display("test %0s: pass, %0d instructions", test_name, count);
		end else begin
			tests_failed++;
			$display("test %0s: FAIL, %0d errors", test_name,
				chk_errors + tb_errors - err_mark);
		end
	endtask

	// retire back-pressure, random only while a stall test runs
	initial begin
		retire_ready = 1'b1;
		rdy_lfsr = SEED;
		rdy_bits = '0;
		forever begin
			@(negedge clk);
			if (stall_mode) begin
				// ready one cycle in eight, so the queue and decoder slot fill up
				for (int k = 0; k < 3; k++) begin
					rdy_lfsr = lfsr_step(rdy_lfsr);
					rdy_bits = {rdy_bits[1:0], rdy_lfsr[0]};
				end
				retire_ready = &rdy_bits;
			end else begin
				retire_ready = 1'b1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the DUT stopped retiring",
			WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		ins_cyc = 1'b0;
		ins_stb = 1'b0;
		ins_we = 1'b1;
		ins_dat = '0;
		stall_mode = 1'b0;
		lfsr = SEED;
		prev_rd = 5'd0;
		tb_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		if (ins_ack !== 1'b0 || retire_valid !== 1'b0) begin
			$display("ins_ack_o or retire_valid_o is not low after reset");
			tb_errors++;
		end
		run_traffic(KIND_R, N_RESET, 1'b0);
		end_test(N_RESET);

		start_test("r_type");
		run_traffic(KIND_R, N_RTYPE, 1'b0);
		end_test(N_RTYPE);

		start_test("i_type");
		run_traffic(KIND_I, N_ITYPE, 1'b0);
		end_test(N_ITYPE);

		start_test("dep_chain");
		run_traffic(KIND_CHAIN, N_CHAIN, 1'b0);
		end_test(N_CHAIN);

		start_test("backpressure");
		run_traffic(KIND_MIX, N_STALL, 1'b1);
		end_test(N_STALL);

		start_test("illegal");
		run_traffic(KIND_ILLEGAL, N_ILLEGAL, 1'b0);
		end_test(N_ILLEGAL);

		$display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, chk_errors + tb_errors);
		if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
